// ==== src/doa_geom_pkg.sv ====
package doa_geom_pkg;

    ////////////////////
    // acoustics and array geometry

    localparam int SAMPLE_FREQ = 46875;  // Hz
    localparam int SOUND_SPEED = 340;    // m/s
    localparam int MIC_DIS_CM  = 6;      // mic spacing in cm

    ////////////////////
    // arccos table layout

    localparam int COS_SCALE   = 1000;   // cosine steps per unit
    localparam int ADDR_OFFSET = 999;    // address of cos = 0
    localparam int ROM_DEPTH   = 1999;

    // path difference in thousandths of a cm, divided by spacing in cm,
    // gives cos(theta) * COS_SCALE; both divisions truncate toward zero
    function automatic int lag_to_addr(input int lag);
        int distance;
        distance = lag * 100000 * SOUND_SPEED / SAMPLE_FREQ;
        return distance / MIC_DIS_CM + ADDR_OFFSET;
    endfunction

endpackage

// ==== src/doa_ctrl_pkg.sv ====
package doa_ctrl_pkg;

    ////////////////////
    // word widths

    localparam int SAMPLE_W = 12;  // signed mic sample
    localparam int LAG_W    = 6;   // signed lag in samples
    localparam int ANGLE_W  = 16;  // hundredths of a degree
    localparam int ADDR_W   = 11;  // arccos table address

    ////////////////////
    // correlator FSM

    typedef enum logic [1:0] {
        IDLE,    // one cycle after reset
        ACCUM,   // summing products over a frame
        SEARCH,  // peak scan, one lag per cycle
        EMIT     // lag out with ena
    } xcorr_state_t;

endpackage

// ==== src/acos_rom.sv ====
module acos_rom
    import doa_geom_pkg::*;
    import doa_ctrl_pkg::*;
(
    input  logic               clk_60MHz,
    input  logic [ADDR_W-1:0]  addr,
    output logic [ANGLE_W-1:0] dout
);

    localparam real PI = 3.14159265358979;

    logic [ANGLE_W-1:0] rom [ROM_DEPTH];

    ////////////////////
    // table contents

    // entry n = acos((n - ADDR_OFFSET) / COS_SCALE), in 0.01 degree
    initial begin
        real cos_val;
        real deg_x100;
        for (int n = 0; n < ROM_DEPTH; n++) begin
            cos_val  = real'(n - ADDR_OFFSET) / real'(COS_SCALE);
            deg_x100 = $acos(cos_val) * 18000.0 / PI;
            rom[n]   = ANGLE_W'($rtoi(deg_x100 + 0.5));  // round half up
        end
    end

    ////////////////////
    // registered read

    always_ff @(posedge clk_60MHz) begin
        dout <= rom[addr];
    end

endmodule

// ==== src/xcorr_lag.sv ====
module xcorr_lag
    import doa_ctrl_pkg::*;
#(
    parameter int FRAME_LEN = 64,
    parameter int MAX_LAG   = 8
) (
    input  logic                       clk_60MHz,
    input  logic                       rst_n,
    input  logic                       sample_valid,
    input  logic signed [SAMPLE_W-1:0] mic_a,
    input  logic signed [SAMPLE_W-1:0] mic_b,
    output logic signed [LAG_W-1:0]    lag_diff,
    output logic                       ena
);

    localparam int NTAP  = 2 * MAX_LAG + 1;                    // lags -MAX_LAG..+MAX_LAG
    localparam int PROD_W = 2 * SAMPLE_W;
    localparam int ACC_W = PROD_W + $clog2(FRAME_LEN) + 1;
    localparam int CNT_W = $clog2(FRAME_LEN);
    localparam int IDX_W = $clog2(NTAP);

    xcorr_state_t state;

    logic [CNT_W-1:0]  frame_cnt;
    logic [IDX_W-1:0]  scan_idx;
    logic [IDX_W-1:0]  best_idx;
    logic signed [ACC_W-1:0] best_sum;

    logic signed [SAMPLE_W-1:0] a_hist [MAX_LAG];      // mic_a delay line
    logic signed [SAMPLE_W-1:0] b_hist [2 * MAX_LAG];  // past mic_b samples
    logic signed [SAMPLE_W-1:0] b_tap  [NTAP];         // current + past mic_b
    logic signed [SAMPLE_W-1:0] a_del;
    logic signed [PROD_W-1:0]   prod   [NTAP];
    logic signed [ACC_W-1:0]    sums   [NTAP];         // one per lag

    logic acc_en;

    assign acc_en = (state == ACCUM) && sample_valid;
    assign a_del  = a_hist[MAX_LAG-1];  // mic_a from MAX_LAG strobes back

    ////////////////////
    // products per lag

    // sum index i holds lag i - MAX_LAG; it pairs delayed mic_a with
    // the mic_b tap 2*MAX_LAG - i strobes old
    always_comb begin
        b_tap[0] = mic_b;
        for (int k = 1; k < NTAP; k++) begin
            b_tap[k] = b_hist[k-1];
        end
        for (int i = 0; i < NTAP; i++) begin
            prod[i] = a_del * b_tap[NTAP-1-i];
        end
    end

    ////////////////////
    // history and sums

    always_ff @(posedge clk_60MHz or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < MAX_LAG; j++) begin
                a_hist[j] <= '0;
            end
            for (int j = 0; j < 2 * MAX_LAG; j++) begin
                b_hist[j] <= '0;
            end
            for (int i = 0; i < NTAP; i++) begin
                sums[i] <= '0;
            end
        end else if (acc_en) begin
            a_hist[0] <= mic_a;
            for (int j = 1; j < MAX_LAG; j++) begin
                a_hist[j] <= a_hist[j-1];
            end
            b_hist[0] <= mic_b;
            for (int j = 1; j < 2 * MAX_LAG; j++) begin
                b_hist[j] <= b_hist[j-1];
            end
            for (int i = 0; i < NTAP; i++) begin
                sums[i] <= sums[i] + prod[i];
            end
        end else if (state == IDLE || state == EMIT) begin
            for (int i = 0; i < NTAP; i++) begin
                sums[i] <= '0;  // fresh frame, history kept
            end
        end
    end

    ////////////////////
    // frame FSM and peak search

    always_ff @(posedge clk_60MHz or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            frame_cnt <= '0;
            scan_idx  <= '0;
            best_idx  <= '0;
            best_sum  <= '0;
            lag_diff  <= '0;
            ena       <= 1'b0;
        end else begin
            ena <= 1'b0;
            case (state)
                IDLE: begin
                    state <= ACCUM;
                end
                ACCUM: begin
                    if (sample_valid) begin
                        if (frame_cnt == CNT_W'(FRAME_LEN - 1)) begin
                            frame_cnt <= '0;
                            scan_idx  <= '0;
                            state     <= SEARCH;
                        end else begin
                            frame_cnt <= frame_cnt + 1'b1;
                        end
                    end
                end
                SEARCH: begin
                    // strict compare, lowest lag keeps a tie
                    if (scan_idx == '0 || sums[scan_idx] > best_sum) begin
                        best_sum <= sums[scan_idx];
                        best_idx <= scan_idx;
                    end
                    if (scan_idx == IDX_W'(NTAP - 1)) begin
                        state <= EMIT;
                    end else begin
                        scan_idx <= scan_idx + 1'b1;
                    end
                end
                EMIT: begin
                    lag_diff <= LAG_W'(int'(best_idx) - MAX_LAG);
                    ena      <= 1'b1;
                    state    <= ACCUM;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== src/bi_microphone.sv ====
module bi_microphone
    import doa_geom_pkg::*;
    import doa_ctrl_pkg::*;
#(
    parameter int AVG_NUM = 6
) (
    input  logic                    clk_60MHz,
    input  logic                    rst_n,
    input  logic                    ena,
    input  logic signed [LAG_W-1:0] lag_diff,
    output logic [ANGLE_W-1:0]      angle,
    output logic                    done
);

    localparam int SUM_W = ANGLE_W + $clog2(AVG_NUM) + 1;
    localparam int CNT_W = $clog2(AVG_NUM + 1);

    logic [ADDR_W-1:0]  addr_r;
    logic [ANGLE_W-1:0] abs_angle;  // rom output, 0 to 180 deg
    logic               ena_r;      // rom address valid
    logic               ena_rr;     // rom data valid
    logic [SUM_W-1:0]   angle_sum;
    logic [SUM_W-1:0]   sum_next;
    logic [CNT_W-1:0]   avg_cnt;

    ////////////////////
    // lag to table address

    always_ff @(posedge clk_60MHz) begin
        if (ena) begin
            addr_r <= ADDR_W'(lag_to_addr(int'(lag_diff)));
        end
    end

    acos_rom acos_rom_i (
        .clk_60MHz (clk_60MHz),
        .addr      (addr_r),
        .dout      (abs_angle)
    );

    always_ff @(posedge clk_60MHz or negedge rst_n) begin
        if (!rst_n) begin
            ena_r  <= 1'b0;
            ena_rr <= 1'b0;
        end else begin
            ena_r  <= ena;
            ena_rr <= ena_r;
        end
    end

    ////////////////////
    // angle averaging

    assign sum_next = angle_sum + SUM_W'(abs_angle);

    always_ff @(posedge clk_60MHz or negedge rst_n) begin
        if (!rst_n) begin
            angle_sum <= '0;
            avg_cnt   <= '0;
            angle     <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (ena_rr) begin
                if (avg_cnt == CNT_W'(AVG_NUM - 1)) begin
                    // last angle of the set goes straight into the average
                    angle     <= ANGLE_W'(sum_next / SUM_W'(AVG_NUM));
                    done      <= 1'b1;
                    angle_sum <= '0;
                    avg_cnt   <= '0;
                end else begin
                    angle_sum <= sum_next;
                    avg_cnt   <= avg_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/doa_top.sv ====
module doa_top
    import doa_ctrl_pkg::*;
#(
    parameter int FRAME_LEN = 64,  // samples per correlation
    parameter int MAX_LAG   = 8,   // 6 cm at 46875 Hz
    parameter int AVG_NUM   = 6
) (
    input  logic                       clk_60MHz,
    input  logic                       rst_n,
    input  logic                       sample_valid,
    input  logic signed [SAMPLE_W-1:0] mic_a,
    input  logic signed [SAMPLE_W-1:0] mic_b,
    output logic signed [LAG_W-1:0]    lag_diff,
    output logic                       lag_valid,
    output logic [ANGLE_W-1:0]         angle,
    output logic                       done
);

    ////////////////////
    // correlator

    // lag_valid doubles as the angle block's ena
    xcorr_lag #(
        .FRAME_LEN (FRAME_LEN),
        .MAX_LAG   (MAX_LAG)
    ) xcorr_lag_i (
        .clk_60MHz    (clk_60MHz),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .mic_a        (mic_a),
        .mic_b        (mic_b),
        .lag_diff     (lag_diff),
        .ena          (lag_valid)
    );

    ////////////////////
    // angle lookup and average

    bi_microphone #(
        .AVG_NUM (AVG_NUM)
    ) bi_microphone_i (
        .clk_60MHz (clk_60MHz),
        .rst_n     (rst_n),
        .ena       (lag_valid),
        .lag_diff  (lag_diff),
        .angle     (angle),
        .done      (done)
    );

endmodule

// ==== sim/doa_tb.sv ====
module doa_tb
    import doa_geom_pkg::*;
    import doa_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int  FRAME_LEN    = 64;
    localparam int  MAX_LAG      = 8;
    localparam int  AVG_NUM      = 6;
    localparam int  SAMPLE_GAP   = 32;   // cycles between strobes
    localparam int  CLK_PERIOD   = 100;  // ns
    localparam int  RESET_CYCLES = 10;
    localparam int  TEST_FRAMES  = 72;   // upper bound over all tests
    localparam int  WATCHDOG_NS  = 2 * TEST_FRAMES * FRAME_LEN * SAMPLE_GAP * CLK_PERIOD;
    localparam int  LV_LIMIT     = 2 * FRAME_LEN * SAMPLE_GAP;  // cycles
    localparam real PI           = 3.14159265358979;

    logic                       clk_60MHz = 1'b0;
    logic                       rst_n;
    logic                       sample_valid;
    logic signed [SAMPLE_W-1:0] mic_a;
    logic signed [SAMPLE_W-1:0] mic_b;
    logic signed [LAG_W-1:0]    lag_diff;
    logic                       lag_valid;
    logic [ANGLE_W-1:0]         angle;
    logic                       done;

    int seed          = 39044;
    int cur_lag       = 0;  // lag applied from the next strobe
    int lv_count      = 0;  // lag_valid pulses since reset
    int done_count    = 0;

    logic signed [SAMPLE_W-1:0] x_hist [MAX_LAG+1];  // newest first

    doa_top #(
        .FRAME_LEN (FRAME_LEN),
        .MAX_LAG   (MAX_LAG),
        .AVG_NUM   (AVG_NUM)
    ) doa_top_i (
        .clk_60MHz    (clk_60MHz),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .mic_a        (mic_a),
        .mic_b        (mic_b),
        .lag_diff     (lag_diff),
        .lag_valid    (lag_valid),
        .angle        (angle),
        .done         (done)
    );

    always #(CLK_PERIOD / 2) clk_60MHz = ~clk_60MHz;

    ////////////////////
    // sample source

    // the later mic gets the same random sequence delayed
    initial begin : stimulus
        sample_valid = 1'b0;
        mic_a        = '0;
        mic_b        = '0;
        for (int k = 0; k <= MAX_LAG; k++) begin
            x_hist[k] = '0;
        end
        forever begin
            @(posedge clk_60MHz);
            for (int k = MAX_LAG; k > 0; k--) begin
                x_hist[k] = x_hist[k-1];
            end
            x_hist[0] = SAMPLE_W'($random(seed));
            sample_valid <= 1'b1;
            if (cur_lag >= 0) begin
                mic_a <= x_hist[0];
                mic_b <= x_hist[cur_lag];  // mic_b trails
            end else begin
                mic_a <= x_hist[-cur_lag];
                mic_b <= x_hist[0];
            end
            @(posedge clk_60MHz);
            sample_valid <= 1'b0;
            repeat (SAMPLE_GAP - 2) @(posedge clk_60MHz);
        end
    end

    ////////////////////
    // failure handling and checks

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            stop_with_failure($sformatf("FAIL %s: expected %0d, actual %0d",
                                        name, expected, actual));
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_with_failure($sformatf("Timeout: run still busy after %0d ns", WATCHDOG_NS));
    end

    // counts done pulses and flags one held high
    initial begin : done_monitor
        logic done_prev;
        done_prev = 1'b0;
        forever begin
            @(negedge clk_60MHz);
            if (done && done_prev) begin
                stop_with_failure("done stayed high for two cycles in a row");
            end
            if (done) begin
                done_count++;
            end
            done_prev = done;
        end
    end

    ////////////////////
    // reference model

    // lag -> table address -> arccos in 0.01 degree
    function automatic int angle_of(input int lag);
        int  distance;
        int  addr;
        real cos_val;
        distance = lag * 100000 * SOUND_SPEED / SAMPLE_FREQ;
        addr     = distance / MIC_DIS_CM + ADDR_OFFSET;
        cos_val  = real'(addr - ADDR_OFFSET) / real'(COS_SCALE);
        return $rtoi($acos(cos_val) * 18000.0 / PI + 0.5);
    endfunction

    ////////////////////
    // helpers

    task automatic apply_reset(input string name);
        @(posedge clk_60MHz);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk_60MHz);
            check({name, " done in reset"}, 0, int'(done));
            check({name, " lag_valid in reset"}, 0, int'(lag_valid));
            check({name, " angle in reset"}, 0, int'(angle));
        end
        @(posedge clk_60MHz);
        rst_n    <= 1'b1;
        lv_count = 0;
    endtask

    // waits for a lag, then checks done over the next 4 cycles
    task automatic next_lag_valid(input string name, output int lag);
        int waited;
        bit set_end;
        waited = 0;
        @(negedge clk_60MHz);
        while (!lag_valid) begin
            if (waited == LV_LIMIT) begin
                stop_with_failure($sformatf("no lag_valid pulse within %0d cycles in %s",
                                            LV_LIMIT, name));
            end
            waited++;
            @(negedge clk_60MHz);
        end
        lag = int'(lag_diff);
        lv_count++;
        set_end = (lv_count % AVG_NUM == 0);  // last lag of an average
        for (int k = 1; k <= 4; k++) begin
            @(negedge clk_60MHz);
            check({name, " done timing"}, (set_end && k == 3) ? 1 : 0, int'(done));
        end
    endtask

    task automatic sync_to_average(input string name);
        int lag;
        while (lv_count % AVG_NUM != 0) begin
            next_lag_valid(name, lag);
        end
    endtask

    ////////////////////
    // tests

    task automatic test_reset();
        apply_reset("test_reset");
        repeat (5) begin
            @(negedge clk_60MHz);
            check("test_reset done", 0, int'(done));
            check("test_reset lag_valid", 0, int'(lag_valid));
            check("test_reset angle", 0, int'(angle));
        end
    endtask

    task automatic test_lag_detect();
        int lags [5];
        int got;
        lags = '{0, 3, -5, 8, -8};
        foreach (lags[i]) begin
            cur_lag = lags[i];
            next_lag_valid("test_lag_detect", got);  // warm-up frame
            repeat (2) begin
                next_lag_valid("test_lag_detect", got);
                check($sformatf("test_lag_detect lag %0d", lags[i]), lags[i], got);
            end
        end
    endtask

    task automatic test_average_constant();
        int got;
        int dc0;
        cur_lag = 4;
        next_lag_valid("test_average_constant", got);
        sync_to_average("test_average_constant");
        dc0 = done_count;
        repeat (AVG_NUM) begin
            next_lag_valid("test_average_constant", got);
            check("test_average_constant lag", 4, got);
        end
        check("test_average_constant done count", 1, done_count - dc0);
        check("test_average_constant angle", angle_of(4), int'(angle));
    endtask

    task automatic test_average_mixed();
        int mixed [6];
        int got;
        int sum;
        mixed = '{1, 2, 3, -2, 0, 5};
        sum   = 0;
        sync_to_average("test_average_mixed");
        foreach (mixed[i]) begin
            cur_lag = mixed[i];
            next_lag_valid("test_average_mixed", got);
            sum += angle_of(got);  // reported lag, not driven
        end
        check("test_average_mixed angle", sum / AVG_NUM, int'(angle));
    endtask

    task automatic test_done_count();
        int got;
        int dc0;
        sync_to_average("test_done_count");
        dc0 = done_count;
        repeat (2 * AVG_NUM) begin
            next_lag_valid("test_done_count", got);
        end
        check("test_done_count pulses", 2, done_count - dc0);
    endtask

    task automatic test_reset_midway();
        int got;
        int dc0;
        sync_to_average("test_reset_midway");
        repeat (3) begin
            next_lag_valid("test_reset_midway", got);
        end
        apply_reset("test_reset_midway");
        dc0 = done_count;
        repeat (AVG_NUM - 1) begin
            next_lag_valid("test_reset_midway", got);
        end
        check("test_reset_midway early done", 0, done_count - dc0);
        next_lag_valid("test_reset_midway", got);
        check("test_reset_midway done", 1, done_count - dc0);
    endtask

    initial begin
        rst_n = 1'b0;
        test_reset();
        test_lag_detect();
        test_average_constant();
        test_average_mixed();
        test_done_count();
        test_reset_midway();
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== sources.f ====
src/doa_geom_pkg.sv
src/doa_ctrl_pkg.sv
src/acos_rom.sv
src/xcorr_lag.sv
src/bi_microphone.sv
src/doa_top.sv
sim/doa_tb.sv

// ==== Makefile ====
# Verilator flow for the direction finder

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= doa_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
LINT_OPTS ?= --lint-only
BUILD_OPTS ?= --binary -Wno-fatal
PASS_MSG  ?= All tests passed!

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) $(BUILD_OPTS) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up in the output
sim: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
